//--- include/gpu_exec_consts.svh
// Instruction format widths and reset constants, included by every execute-control source file
`ifndef GPU_EXEC_CONSTS_SVH
`define GPU_EXEC_CONSTS_SVH

// Full instruction word as delivered by fetch
`define GPU_INS_W 16

// Opcode field in bits 15..10
`define GPU_OPC_W 6

// Source and destination operand fields
// srcop sits in bits 9..5, dstop in bits 4..0
`define GPU_REG_W 5

// Register address is the bank bit above an operand field
`define GPU_RA_W 6

// MOVEI immediate, two instruction words
`define GPU_IMM_W 32

// Program counter, byte address of 16-bit words
`define GPU_PC_W 24

// Start of local program RAM
`define GPU_PC_RESET 24'hF03000

`endif

//--- hdl/gpu_exec_pkg.sv
// Shared types of the execute control: opcodes, sequencer states and the microcode word
`include "gpu_exec_consts.svh"

package gpu_exec_pkg;

	// Kept opcodes, numbered as in the instruction set
	// Codes not listed here are treated as NOP by decode
	typedef enum logic [`GPU_OPC_W-1:0] {
		ADD   = 6'd0,
		SUB   = 6'd4,
		AND   = 6'd9,
		OR    = 6'd10,
		XOR   = 6'd11,
		MOVEI = 6'd38,
		LOAD  = 6'd41,
		STORE = 6'd47,
		JR    = 6'd53,
		NOP   = 6'd57
	} opcode_e;

	// Instruction sequencer
	typedef enum logic [1:0] {
		// Normal issue, one word per instruction
		SEQ_RUN    = 2'd0,
		// MOVEI seen, next word is immediate bits 15..0
		SEQ_IMM_LO = 2'd1,
		// Next word is immediate bits 31..16
		SEQ_IMM_HI = 2'd2
	} seq_state_e;

	// Microcode word, one per opcode
	// alufunc encoding
	//   000 add, 010 sub, 100 and, 101 or, 110 xor
	// ressel encoding
	//   000 ALU result, 001 immediate, 010 memory data
	typedef struct packed {
		logic [2:0] alufunc;
		logic [2:0] ressel;
		// Load the ALU flags
		logic       flagld;
		// Load the result register
		logic       resld;
		// Write result to the register file
		logic       reswr;
		// Destination register write enable
		logic       dstwen;
		// Memory cycle request
		logic       memrw;
		// Memory cycle is a write
		logic       datwe;
		// Immediate data onto the result bus
		logic       immld;
		// Relative jump
		logic       jumprel;
	} microword_t;

endpackage

//--- hdl/ins_dec_if.sv
// Decoded instruction bundle from the decode register to sequencer, branch unit and register addressing
`timescale 1ns/1ps
`include "gpu_exec_consts.svh"

interface ins_dec_if;

	// Held instruction fields
	gpu_exec_pkg::opcode_e    opcode;
	logic [`GPU_REG_W-1:0]    srcop;
	logic [`GPU_REG_W-1:0]    dstop;
	// Microcode looked up from opcode
	gpu_exec_pkg::microword_t mword;
	// Decode register holds an instruction
	logic                     dec_valid;

	// Decode stage owns every signal
	modport dec (output opcode, srcop, dstop, mword, dec_valid);
	// Sequencer checks the MOVEI it is completing
	modport seq (input opcode, dec_valid);
	// Branch unit uses the condition mask and offset
	modport br (input srcop, dstop, mword);
	// Register address formation
	modport ra (input srcop, dstop);

endinterface

//--- hdl/exec_seq.sv
// Instruction issue FSM, accepts fetch words, steers MOVEI immediates and times the execute pulse
`timescale 1ns/1ps
`include "gpu_exec_consts.svh"

module exec_seq (
	input  logic                  sys_clk,
	input  logic                  resetl,
	input  logic                  go,
	input  logic                  ins_valid,
	input  logic [`GPU_INS_W-1:0] ins_data,
	ins_dec_if.seq                dec,
	output logic                  ins_ack,
	output logic                  exe,
	output logic                  imm_lo_ld,
	output logic                  imm_hi_ld
);

	gpu_exec_pkg::seq_state_e state_q;
	gpu_exec_pkg::seq_state_e state_nxt;
	logic                     word_movei;
	logic                     movei_done;
	logic                     exe_nxt;

	// Word taken whenever running and fetch has one
	assign ins_ack = go & ins_valid;

	// Opcode field of the word on the bus
	assign word_movei = ins_data[`GPU_INS_W-1 -: `GPU_OPC_W] == gpu_exec_pkg::MOVEI;

	// Immediate halves follow the MOVEI word in order
	assign imm_lo_ld = ins_ack & (state_q == gpu_exec_pkg::SEQ_IMM_LO);
	assign imm_hi_ld = ins_ack & (state_q == gpu_exec_pkg::SEQ_IMM_HI);

	// Decode must still hold the MOVEI that opened the sequence
	assign movei_done = imm_hi_ld & dec.dec_valid & (dec.opcode == gpu_exec_pkg::MOVEI);

	always_comb begin
		state_nxt = state_q;
		exe_nxt   = 1'b0;
		case (state_q)
			gpu_exec_pkg::SEQ_RUN: begin
				if (ins_ack) begin
					// MOVEI waits for its data words, anything else executes next cycle
					if (word_movei) begin
						state_nxt = gpu_exec_pkg::SEQ_IMM_LO;
					end else begin
						exe_nxt = 1'b1;
					end
				end
			end
			gpu_exec_pkg::SEQ_IMM_LO: begin
				if (ins_ack) begin
					state_nxt = gpu_exec_pkg::SEQ_IMM_HI;
				end
			end
			gpu_exec_pkg::SEQ_IMM_HI: begin
				// Full immediate present after this edge
				if (ins_ack) begin
					state_nxt = gpu_exec_pkg::SEQ_RUN;
					exe_nxt   = movei_done;
				end
			end
			default: begin
				state_nxt = gpu_exec_pkg::SEQ_RUN;
			end
		endcase
	end

	// exe is the registered execute-pending flag, one cycle per issue
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state_q <= gpu_exec_pkg::SEQ_RUN;
			exe     <= 1'b0;
		end else begin
			state_q <= state_nxt;
			exe     <= exe_nxt;
		end
	end

endmodule

//--- hdl/ins_decode.sv
// Decode register, microcode table and MOVEI immediate assembly, drives the execute strobes
`timescale 1ns/1ps
`include "gpu_exec_consts.svh"

module ins_decode (
	input  logic                  sys_clk,
	input  logic                  resetl,
	input  logic [`GPU_INS_W-1:0] ins_data,
	input  logic                  ins_ack,
	input  logic                  exe,
	input  logic                  imm_lo_ld,
	input  logic                  imm_hi_ld,
	ins_dec_if.dec                dec,
	output logic [2:0]            alufunc,
	output logic [2:0]            ressel,
	output logic                  dstwen,
	output logic                  flagld,
	output logic                  resld,
	output logic                  reswr,
	output logic                  memrw,
	output logic                  datwe,
	output logic                  immld,
	output logic [`GPU_IMM_W-1:0] immdata
);

	gpu_exec_pkg::opcode_e    opc_in;
	gpu_exec_pkg::opcode_e    opc_q;
	gpu_exec_pkg::microword_t mword_q;
	logic [`GPU_REG_W-1:0]    srcop_q;
	logic [`GPU_REG_W-1:0]    dstop_q;
	logic                     valid_q;
	logic                     dec_ld;
	logic [`GPU_INS_W-1:0]    imm_lo_q;
	logic [`GPU_INS_W-1:0]    imm_hi_q;

	// Unknown opcodes fold onto NOP
	function automatic gpu_exec_pkg::opcode_e opc_map(input logic [`GPU_OPC_W-1:0] code);
		case (code)
			gpu_exec_pkg::ADD, gpu_exec_pkg::SUB, gpu_exec_pkg::AND,
			gpu_exec_pkg::OR, gpu_exec_pkg::XOR, gpu_exec_pkg::MOVEI,
			gpu_exec_pkg::LOAD, gpu_exec_pkg::STORE, gpu_exec_pkg::JR:
				opc_map = gpu_exec_pkg::opcode_e'(code);
			default:
				opc_map = gpu_exec_pkg::NOP;
		endcase
	endfunction

	// Microcode table
	function automatic gpu_exec_pkg::microword_t mcode(input gpu_exec_pkg::opcode_e opc);
		gpu_exec_pkg::microword_t mw;
		mw = '0;
		case (opc)
			gpu_exec_pkg::ADD: mw.alufunc = 3'b000;
			gpu_exec_pkg::SUB: mw.alufunc = 3'b010;
			gpu_exec_pkg::AND: mw.alufunc = 3'b100;
			gpu_exec_pkg::OR:  mw.alufunc = 3'b101;
			gpu_exec_pkg::XOR: mw.alufunc = 3'b110;
			gpu_exec_pkg::MOVEI: begin
				mw.ressel = 3'b001;
				mw.immld  = 1'b1;
			end
			gpu_exec_pkg::LOAD: begin
				mw.ressel = 3'b010;
				mw.memrw  = 1'b1;
			end
			gpu_exec_pkg::STORE: begin
				mw.memrw = 1'b1;
				mw.datwe = 1'b1;
			end
			gpu_exec_pkg::JR: mw.jumprel = 1'b1;
			default: mw = '0;
		endcase
		// ALU ops and MOVEI write a result register
		if (opc inside {gpu_exec_pkg::ADD, gpu_exec_pkg::SUB, gpu_exec_pkg::AND,
				gpu_exec_pkg::OR, gpu_exec_pkg::XOR}) begin
			mw.flagld = 1'b1;
		end
		if (opc inside {gpu_exec_pkg::ADD, gpu_exec_pkg::SUB, gpu_exec_pkg::AND,
				gpu_exec_pkg::OR, gpu_exec_pkg::XOR, gpu_exec_pkg::MOVEI}) begin
			mw.resld  = 1'b1;
			mw.reswr  = 1'b1;
			mw.dstwen = 1'b1;
		end
		return mw;
	endfunction

	assign opc_in = opc_map(ins_data[`GPU_INS_W-1 -: `GPU_OPC_W]);

	// Immediate words do not disturb the held MOVEI
	assign dec_ld = ins_ack & ~imm_lo_ld & ~imm_hi_ld;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			opc_q   <= gpu_exec_pkg::NOP;
			mword_q <= '0;
			srcop_q <= '0;
			dstop_q <= '0;
			valid_q <= 1'b0;
		end else if (dec_ld) begin
			opc_q   <= opc_in;
			mword_q <= mcode(opc_in);
			srcop_q <= ins_data[2*`GPU_REG_W-1:`GPU_REG_W];
			dstop_q <= ins_data[`GPU_REG_W-1:0];
			valid_q <= 1'b1;
		end
	end

	// Immediate halves, held until the next MOVEI
	always_ff @(posedge sys_clk) begin
		if (imm_lo_ld) begin
			imm_lo_q <= ins_data;
		end
		if (imm_hi_ld) begin
			imm_hi_q <= ins_data;
		end
	end

	assign dec.opcode    = opc_q;
	assign dec.srcop     = srcop_q;
	assign dec.dstop     = dstop_q;
	assign dec.mword     = mword_q;
	assign dec.dec_valid = valid_q;

	// Function selects are static, strobes only in the exe cycle
	assign alufunc = mword_q.alufunc;
	assign ressel  = mword_q.ressel;
	assign dstwen  = exe & mword_q.dstwen;
	assign flagld  = exe & mword_q.flagld;
	assign resld   = exe & mword_q.resld;
	assign reswr   = exe & mword_q.reswr;
	assign memrw   = exe & mword_q.memrw;
	assign datwe   = exe & mword_q.datwe;
	assign immld   = exe & mword_q.immld;
	assign immdata = {imm_hi_q, imm_lo_q};

endmodule

//--- hdl/branch_pc.sv
// Program counter with conditional relative jumps, one delay slot after JR
`timescale 1ns/1ps
`include "gpu_exec_consts.svh"

module branch_pc (
	input  logic                 sys_clk,
	input  logic                 resetl,
	input  logic                 ins_ack,
	input  logic                 exe,
	input  logic                 zero_flag,
	input  logic                 carry_flag,
	input  logic                 nega_flag,
	ins_dec_if.br                br,
	output logic [`GPU_PC_W-1:0] prog_count,
	output logic                 jump_taken
);

	logic [`GPU_PC_W-1:0] dec_pc_q;
	logic [`GPU_PC_W-1:0] jr_off;
	logic [`GPU_PC_W-1:0] jr_target;
	logic                 other_flag;
	logic                 cond_ok;

	// dstop bit 4 picks negative or carry as the second flag
	assign other_flag = br.dstop[4] ? nega_flag : carry_flag;

	// Every set mask bit must be met, empty mask always jumps
	assign cond_ok = ~(br.dstop[0] & ~zero_flag) &
		~(br.dstop[1] & zero_flag) &
		~(br.dstop[2] & ~other_flag) &
		~(br.dstop[3] & other_flag);

	assign jump_taken = exe & br.mword.jumprel & cond_ok;

	// srcop is a signed word offset from the delay slot
	assign jr_off    = {{(`GPU_PC_W-`GPU_REG_W-1){br.srcop[`GPU_REG_W-1]}}, br.srcop, 1'b0};
	assign jr_target = dec_pc_q + `GPU_PC_W'(2) + jr_off;

	// Jump wins over the increment of the delay slot accept
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			prog_count <= `GPU_PC_RESET;
		end else if (jump_taken) begin
			prog_count <= jr_target;
		end else if (ins_ack) begin
			prog_count <= prog_count + `GPU_PC_W'(2);
		end
	end

	// Address of the word now in decode
	always_ff @(posedge sys_clk) begin
		if (ins_ack) begin
			dec_pc_q <= prog_count;
		end
	end

endmodule

//--- hdl/reg_addr_gen.sv
// Register bank flag and 6-bit source and destination register address formation
`timescale 1ns/1ps
`include "gpu_exec_consts.svh"

module reg_addr_gen (
	input  logic                 sys_clk,
	input  logic                 resetl,
	input  logic                 flagwr,
	input  logic                 flag_page,
	ins_dec_if.ra                ra,
	output logic [`GPU_RA_W-1:0] dstat,
	output logic [`GPU_RA_W-1:0] srcat
);

	logic bank_q;

	// Bank bit written along with the flags register
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			bank_q <= 1'b0;
		end else if (flagwr) begin
			bank_q <= flag_page;
		end
	end

	// Bank 1 is the upper 32 registers
	// Both operands share the same bank
	assign dstat = {bank_q, ra.dstop};
	assign srcat = {bank_q, ra.srcop};

endmodule

//--- hdl/gpu_ins_exec.sv
// Top level of the instruction execute control, wires sequencer, decode, branch and addressing
`timescale 1ns/1ps
`include "gpu_exec_consts.svh"

module gpu_ins_exec (
	input  logic                  sys_clk,
	input  logic                  resetl,
	input  logic                  go,
	input  logic                  ins_valid,
	input  logic [`GPU_INS_W-1:0] ins_data,
	input  logic                  zero_flag,
	input  logic                  carry_flag,
	input  logic                  nega_flag,
	input  logic                  flagwr,
	input  logic                  flag_page,
	output logic                  ins_ack,
	output logic                  exe,
	output logic [2:0]            alufunc,
	output logic [2:0]            ressel,
	output logic                  dstwen,
	output logic                  flagld,
	output logic                  resld,
	output logic                  reswr,
	output logic                  memrw,
	output logic                  datwe,
	output logic                  immld,
	output logic [`GPU_IMM_W-1:0] immdata,
	output logic [`GPU_RA_W-1:0]  dstat,
	output logic [`GPU_RA_W-1:0]  srcat,
	output logic                  jump_taken,
	output logic [`GPU_PC_W-1:0]  prog_count
);

	// Immediate half capture from sequencer into decode
	logic imm_lo_ld;
	logic imm_hi_ld;

	// Decoded instruction bundle
	ins_dec_if u_dec_if ();

	// Issue FSM
	exec_seq u_exec_seq (
		.sys_clk   (sys_clk),
		.resetl    (resetl),
		.go        (go),
		.ins_valid (ins_valid),
		.ins_data  (ins_data),
		.dec       (u_dec_if.seq),
		.ins_ack   (ins_ack),
		.exe       (exe),
		.imm_lo_ld (imm_lo_ld),
		.imm_hi_ld (imm_hi_ld)
	);

	// Decode register and strobes
	ins_decode u_ins_decode (
		.sys_clk   (sys_clk),
		.resetl    (resetl),
		.ins_data  (ins_data),
		.ins_ack   (ins_ack),
		.exe       (exe),
		.imm_lo_ld (imm_lo_ld),
		.imm_hi_ld (imm_hi_ld),
		.dec       (u_dec_if.dec),
		.alufunc   (alufunc),
		.ressel    (ressel),
		.dstwen    (dstwen),
		.flagld    (flagld),
		.resld     (resld),
		.reswr     (reswr),
		.memrw     (memrw),
		.datwe     (datwe),
		.immld     (immld),
		.immdata   (immdata)
	);

	// Program counter and JR
	branch_pc u_branch_pc (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.ins_ack    (ins_ack),
		.exe        (exe),
		.zero_flag  (zero_flag),
		.carry_flag (carry_flag),
		.nega_flag  (nega_flag),
		.br         (u_dec_if.br),
		.prog_count (prog_count),
		.jump_taken (jump_taken)
	);

	// Register bank and addresses
	reg_addr_gen u_reg_addr_gen (
		.sys_clk   (sys_clk),
		.resetl    (resetl),
		.flagwr    (flagwr),
		.flag_page (flag_page),
		.ra        (u_dec_if.ra),
		.dstat     (dstat),
		.srcat     (srcat)
	);

endmodule

//--- verif/gpu_ins_exec_assertions.sv
// Concurrent timing checks on the execute control top level, bound into every gpu_ins_exec
`timescale 1ns/1ps
`include "gpu_exec_consts.svh"

module gpu_ins_exec_assertions (
	input logic                  sys_clk,
	input logic                  resetl,
	input logic                  ins_ack,
	input logic                  exe,
	input logic                  immld,
	input logic                  jump_taken,
	input logic                  imm_lo_ld,
	input logic                  imm_hi_ld,
	input logic [`GPU_INS_W-1:0] ins_data,
	input logic [`GPU_RA_W-1:0]  srcat,
	input logic [`GPU_PC_W-1:0]  prog_count
);

	logic movei_acc;

	// MOVEI taken as an instruction, immediate data words excluded
	assign movei_acc = ins_ack & ~imm_lo_ld & ~imm_hi_ld &
		(ins_data[`GPU_INS_W-1 -: `GPU_OPC_W] == gpu_exec_pkg::MOVEI);

	// Nothing accepted or executed while reset is held
	a_rst_ack: assert property (@(posedge sys_clk) !resetl |-> !ins_ack)
		else $error("ins_ack high during reset");
	a_rst_exe: assert property (@(posedge sys_clk) !resetl |=> !exe)
		else $error("exe high after a reset cycle");

	// immld only in the exe that follows the high immediate word
	a_immld: assert property (@(posedge sys_clk) disable iff (!resetl)
		immld == (exe && $past(imm_hi_ld)))
		else $error("immld outside the exe that completes a MOVEI");

	// Taken JR in its exe cycle, target counted from the delay slot address
	a_jump: assert property (@(posedge sys_clk) disable iff (!resetl)
		jump_taken |=> $past(exe) &&
			prog_count == $past(prog_count + `GPU_PC_W'(2 * $signed(srcat[`GPU_REG_W-1:0]))))
		else $error("jump_taken outside exe or without the relative target load");

	// MOVEI waits for both immediate words
	a_movei: assert property (@(posedge sys_clk) disable iff (!resetl) movei_acc |=> !exe)
		else $error("exe directly after MOVEI acceptance");

endmodule

bind gpu_ins_exec gpu_ins_exec_assertions u_assert (
	.sys_clk    (sys_clk),
	.resetl     (resetl),
	.ins_ack    (ins_ack),
	.exe        (exe),
	.immld      (immld),
	.jump_taken (jump_taken),
	.imm_lo_ld  (imm_lo_ld),
	.imm_hi_ld  (imm_hi_ld),
	.ins_data   (ins_data),
	.srcat      (srcat),
	.prog_count (prog_count)
);

//--- verif/tb_gpu_ins_exec.sv
// Directed testbench for the execute control, run as top module tb_gpu_ins_exec
`timescale 1ns/1ps
`include "gpu_exec_consts.svh"

module tb_gpu_ins_exec;

	// Expected strobes {dstwen/resld/reswr, flagld, memrw, datwe, immld}
	localparam logic [4:0] str_alu   = 5'b11000;
	localparam logic [4:0] str_load  = 5'b00100;
	localparam logic [4:0] str_store = 5'b00110;
	localparam logic [4:0] str_movei = 5'b10001;
	localparam logic [4:0] str_none  = 5'b00000;

	logic                  sys_clk = 1'b0;
	logic                  resetl;
	logic                  go;
	logic                  ins_valid;
	logic [`GPU_INS_W-1:0] ins_data;
	logic                  zero_flag;
	logic                  carry_flag;
	logic                  nega_flag;
	logic                  flagwr;
	logic                  flag_page;
	logic                  ins_ack;
	logic                  exe;
	logic [2:0]            alufunc;
	logic [2:0]            ressel;
	logic                  dstwen;
	logic                  flagld;
	logic                  resld;
	logic                  reswr;
	logic                  memrw;
	logic                  datwe;
	logic                  immld;
	logic [`GPU_IMM_W-1:0] immdata;
	logic [`GPU_RA_W-1:0]  dstat;
	logic [`GPU_RA_W-1:0]  srcat;
	logic                  jump_taken;
	logic [`GPU_PC_W-1:0]  prog_count;

	// Scoreboard state
	logic [`GPU_PC_W-1:0]  exp_pc;
	logic                  bank_exp;
	logic [31:0]           lfsr_state = 32'h967b64e7;
	int                    err_cnt = 0;
	int                    err_mark = 0;
	int                    chk_cnt = 0;
	int                    test_cnt = 0;

	// 100 ns clock
	always #50 sys_clk = ~sys_clk;

	gpu_ins_exec u_dut (.*);

	// Galois LFSR, one step per bit
	function automatic int take_bits(input int n);
		int val;
		int i;
		val = 0;
		for (i = 0; i < n; i++) begin
			val = (val << 1) | int'(lfsr_state[0]);
			lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
		end
		return val;
	endfunction

	function automatic logic [15:0] mk_word(input logic [5:0] opc, input logic [4:0] src,
			input logic [4:0] dst);
		return {opc, src, dst};
	endfunction

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			$display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_opc(input string name, input gpu_exec_pkg::opcode_e got,
			input gpu_exec_pkg::opcode_e exp);
		chk_cnt++;
		if (got !== exp) begin
			$display("ERROR at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		chk_cnt++;
		if (got !== exp) begin
			$display("ERROR at %0d ns: %s is %b, expected %b", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_strobes(input logic [4:0] e);
		check_bit("dstwen", dstwen, e[4]);
		check_bit("resld", resld, e[4]);
		check_bit("reswr", reswr, e[4]);
		check_bit("flagld", flagld, e[3]);
		check_bit("memrw", memrw, e[2]);
		check_bit("datwe", datwe, e[1]);
		check_bit("immld", immld, e[0]);
	endtask

	task automatic finish_run();
		$display("Tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	task automatic abort_timeout(input string what);
		$display("Timeout at %0d ns while waiting for %s", $time, what);
		err_cnt++;
		finish_run();
	endtask

	task automatic end_test(input string name);
		$display("Test %s done with %0d errors", name, err_cnt - err_mark);
		err_mark = err_cnt;
		test_cnt++;
	endtask

	// Back to 5 ns after the next rising edge
	task automatic next_cycle();
		@(posedge sys_clk);
		#5;
	endtask

	// Offer a word after a go-low gap, return once it is taken
	task automatic send_word(input logic [15:0] word, input int gap);
		int cnt;
		logic accepted;
		ins_data  = word;
		ins_valid = 1'b1;
		go        = (gap == 0);
		for (cnt = 0; cnt < gap; cnt++) begin
			// Stalled, nothing may advance
			@(negedge sys_clk);
			check_bit("ins_ack", ins_ack, 1'b0);
			check_bit("exe", exe, 1'b0);
			check_word("prog_count", 32'(prog_count), 32'(exp_pc));
			next_cycle();
		end
		go = 1'b1;
		accepted = 1'b0;
		cnt = 0;
		while (!accepted && cnt < 10) begin
			@(posedge sys_clk);
			accepted = ins_ack;
			cnt++;
		end
		if (!accepted) begin
			abort_timeout("ins_ack");
		end else begin
			exp_pc = exp_pc + 24'd2;
			#5;
			ins_valid = 1'b0;
		end
	endtask

	// Sample at falling edges until exe shows
	task automatic wait_exe(input string what);
		int cnt;
		cnt = 0;
		@(negedge sys_clk);
		while (!exe && cnt < 8) begin
			@(negedge sys_clk);
			cnt++;
		end
		if (!exe) begin
			abort_timeout(what);
		end
	endtask

	// One non-MOVEI word through to its exe cycle
	task automatic exec_word(input logic [15:0] word, input int gap,
			input gpu_exec_pkg::opcode_e e_opc, input logic [2:0] e_fn,
			input logic [2:0] e_sel, input logic [4:0] e_str);
		send_word(word, gap);
		wait_exe("exe");
		check_opc("opcode", u_dut.u_dec_if.opcode, e_opc);
		check_word("alufunc", 32'(alufunc), 32'(e_fn));
		check_word("ressel", 32'(ressel), 32'(e_sel));
		check_strobes(e_str);
		check_word("dstat", 32'(dstat), 32'({bank_exp, word[4:0]}));
		check_word("srcat", 32'(srcat), 32'({bank_exp, word[9:5]}));
		check_word("prog_count", 32'(prog_count), 32'(exp_pc));
		next_cycle();
	endtask

	// MOVEI and its two immediate words
	task automatic movei_seq(input logic [4:0] dst, input logic [15:0] lo, input logic [15:0] hi,
			input logic gaps);
		send_word(mk_word(gpu_exec_pkg::MOVEI, 5'd0, dst), gaps ? take_bits(2) + 1 : 0);
		send_word(lo, gaps ? take_bits(2) + 1 : 0);
		send_word(hi, gaps ? take_bits(2) + 1 : 0);
		wait_exe("MOVEI exe");
		check_opc("opcode", u_dut.u_dec_if.opcode, gpu_exec_pkg::MOVEI);
		check_word("ressel", 32'(ressel), 32'h1);
		check_strobes(str_movei);
		check_word("immdata", immdata, {hi, lo});
		check_word("dstat", 32'(dstat), 32'({bank_exp, dst}));
		check_word("prog_count", 32'(prog_count), 32'(exp_pc));
		next_cycle();
	endtask

	// JR plus an ADD in its delay slot
	task automatic jr_case(input logic [4:0] mask, input logic z, input logic c, input logic n,
			input logic exp_jump, input logic [4:0] off);
		logic [`GPU_PC_W-1:0] pc_jr;
		logic [`GPU_PC_W-1:0] exp_tgt;
		int off_i;
		off_i = off[4] ? int'(off) - 32 : int'(off);
		zero_flag  = z;
		carry_flag = c;
		nega_flag  = n;
		pc_jr   = exp_pc;
		exp_tgt = pc_jr + 24'd2 + 24'(2 * off_i);
		send_word(mk_word(gpu_exec_pkg::JR, off, mask), 0);
		// Delay slot word offered during the JR exe cycle
		ins_valid = 1'b1;
		ins_data  = mk_word(gpu_exec_pkg::ADD, 5'd1, 5'd2);
		wait_exe("JR exe");
		check_bit("jump_taken", jump_taken, exp_jump);
		check_bit("ins_ack", ins_ack, 1'b1);
		check_word("prog_count", 32'(prog_count), 32'(pc_jr + 24'd2));
		next_cycle();
		ins_valid = 1'b0;
		exp_pc = exp_jump ? exp_tgt : pc_jr + 24'd4;
		wait_exe("delay slot exe");
		check_bit("dstwen", dstwen, 1'b1);
		check_bit("jump_taken", jump_taken, 1'b0);
		check_word("prog_count", 32'(prog_count), 32'(exp_pc));
		next_cycle();
	endtask

	task automatic test_reset_alu();
		gpu_exec_pkg::opcode_e alu_opc [5];
		logic [2:0] alu_fn [5];
		int i;
		alu_opc = '{gpu_exec_pkg::ADD, gpu_exec_pkg::SUB, gpu_exec_pkg::AND,
			gpu_exec_pkg::OR, gpu_exec_pkg::XOR};
		alu_fn = '{3'b000, 3'b010, 3'b100, 3'b101, 3'b110};
		@(negedge sys_clk);
		check_word("prog_count", 32'(prog_count), 32'(`GPU_PC_RESET));
		check_bit("exe", exe, 1'b0);
		check_bit("jump_taken", jump_taken, 1'b0);
		check_strobes(str_none);
		next_cycle();
		for (i = 0; i < 5; i++) begin
			exec_word(mk_word(alu_opc[i], 5'(i + 3), 5'(2 * i)), 0, alu_opc[i], alu_fn[i],
				3'b000, str_alu);
		end
		end_test("reset_alu");
	endtask

	task automatic test_mem_nop();
		exec_word(mk_word(gpu_exec_pkg::LOAD, 5'd4, 5'd6), 0, gpu_exec_pkg::LOAD, 3'b000,
			3'b010, str_load);
		exec_word(mk_word(gpu_exec_pkg::STORE, 5'd9, 5'd1), 0, gpu_exec_pkg::STORE, 3'b000,
			3'b000, str_store);
		exec_word(mk_word(gpu_exec_pkg::NOP, 5'd0, 5'd0), 0, gpu_exec_pkg::NOP, 3'b000,
			3'b000, str_none);
		// Unlisted codes fold onto NOP
		exec_word(mk_word(6'd20, 5'd3, 5'd3), 0, gpu_exec_pkg::NOP, 3'b000, 3'b000, str_none);
		exec_word(mk_word(6'd63, 5'd31, 5'd31), 0, gpu_exec_pkg::NOP, 3'b000, 3'b000, str_none);
		end_test("mem_nop");
	endtask

	task automatic test_stall();
		int k;
		for (k = 0; k < 3; k++) begin
			exec_word(mk_word(gpu_exec_pkg::SUB, 5'(k), 5'(k + 8)), take_bits(3) + 1,
				gpu_exec_pkg::SUB, 3'b010, 3'b000, str_alu);
		end
		movei_seq(5'd21, 16'h0f0f, 16'h9b00, 1'b1);
		exec_word(mk_word(gpu_exec_pkg::AND, 5'd17, 5'd2), take_bits(2) + 1,
			gpu_exec_pkg::AND, 3'b100, 3'b000, str_alu);
		end_test("stall");
	endtask

	task automatic test_jr();
		jr_case(5'b00001, 1'b1, 1'b0, 1'b0, 1'b1, 5'd3);
		jr_case(5'b00001, 1'b0, 1'b0, 1'b0, 1'b0, 5'd3);
		jr_case(5'b00010, 1'b0, 1'b1, 1'b0, 1'b1, 5'h1e);
		jr_case(5'b00100, 1'b0, 1'b1, 1'b0, 1'b1, 5'd5);
		jr_case(5'b01000, 1'b0, 1'b1, 1'b0, 1'b0, 5'd5);
		jr_case(5'b10100, 1'b0, 1'b0, 1'b1, 1'b1, 5'h10);
		jr_case(5'b11000, 1'b0, 1'b0, 1'b1, 1'b0, 5'd1);
		jr_case(5'b00000, 1'b1, 1'b1, 1'b1, 1'b1, 5'd0);
		jr_case(5'b00101, 1'b1, 1'b0, 1'b0, 1'b0, 5'd2);
		jr_case(5'b10110, 1'b0, 1'b1, 1'b1, 1'b1, 5'h1f);
		zero_flag  = 1'b0;
		carry_flag = 1'b0;
		nega_flag  = 1'b0;
		end_test("jr");
	endtask

	task automatic test_bank();
		// Upper register bank for the following words
		flag_page = 1'b1;
		flagwr    = 1'b1;
		next_cycle();
		flagwr   = 1'b0;
		bank_exp = 1'b1;
		exec_word(mk_word(gpu_exec_pkg::ADD, 5'd7, 5'd19), 0, gpu_exec_pkg::ADD, 3'b000,
			3'b000, str_alu);
		exec_word(mk_word(gpu_exec_pkg::XOR, 5'd31, 5'd0), 0, gpu_exec_pkg::XOR, 3'b110,
			3'b000, str_alu);
		movei_seq(5'd5, 16'h1234, 16'h8765, 1'b0);
		end_test("bank");
	endtask

	initial begin
		resetl     = 1'b0;
		go         = 1'b0;
		ins_valid  = 1'b0;
		ins_data   = '0;
		zero_flag  = 1'b0;
		carry_flag = 1'b0;
		nega_flag  = 1'b0;
		flagwr     = 1'b0;
		flag_page  = 1'b0;
		exp_pc     = `GPU_PC_RESET;
		bank_exp   = 1'b0;
		repeat (8) @(posedge sys_clk);
		#5;
		resetl = 1'b1;
		go     = 1'b1;
		test_reset_alu();
		test_mem_nop();
		// Low word carries the MOVEI opcode pattern on purpose
		movei_seq(5'd12, 16'h9a3c, 16'hc0de, 1'b0);
		end_test("movei");
		test_stall();
		test_jr();
		test_bank();
		finish_run();
	end

endmodule

//--- gpu_ins_exec.f
+incdir+include
hdl/gpu_exec_pkg.sv
hdl/ins_dec_if.sv
hdl/exec_seq.sv
hdl/ins_decode.sv
hdl/branch_pc.sv
hdl/reg_addr_gen.sv
hdl/gpu_ins_exec.sv
verif/gpu_ins_exec_assertions.sv
verif/tb_gpu_ins_exec.sv

//--- Makefile
SRCS := $(shell grep -v '^+' gpu_ins_exec.f)
BIN  := obj_dir/Vtb_gpu_ins_exec

all: run

$(BIN): gpu_ins_exec.f $(SRCS) include/gpu_exec_consts.svh
	verilator --binary --timing --assert --top-module tb_gpu_ins_exec -f gpu_ins_exec.f

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Simulation failed" sim.log || grep -q "%Error" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
